// ==== colour_table/palette_arbiter.sv ====
/* Fixed-priority arbiter for table port A. The fill engine always wins, so bus
   accesses wait until the default palette is written */
module palette_arbiter (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  palette_pkg::ct_req_t  fill_req,
  input  logic                  fill_req_valid,
  output logic                  fill_gnt,
  input  palette_pkg::ct_req_t  bus_req,
  input  logic                  bus_req_valid,
  output logic                  bus_gnt,
  output palette_pkg::ct_req_t  ram_req,
  output logic                  ram_en,
  input  logic [31:0]           ram_rdata,
  output palette_pkg::ct_rsp_t  bus_rsp
);
  import palette_pkg::*;

  logic bus_rd_q; // Last cycle's grant was a bus read

  assign fill_gnt = fill_req_valid;
  assign bus_gnt  = bus_req_valid && !fill_req_valid;
  assign ram_en   = fill_gnt || bus_gnt;

  always_comb begin
    if (fill_gnt) begin
      ram_req = fill_req;
    end else begin
      ram_req = bus_req;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      bus_rd_q <= 1'b0;
    end else begin
      bus_rd_q <= bus_gnt && !bus_req.we;
    end
  end

  // Only the bus slave reads, so the returned word always goes to it
  always_comb begin
    bus_rsp.rvalid = bus_rd_q;
    bus_rsp.rdata  = ram_rdata;
  end

  a_one_grant: assert property (@(posedge aclk) disable iff (!aresetn)
    !(fill_gnt && bus_gnt));

  // A bus request stays raised until the port is granted to it
  a_bus_req_held: assert property (@(posedge aclk) disable iff (!aresetn)
    bus_req_valid && !bus_gnt |=> bus_req_valid);

endmodule

// ==== colour_table/palette_axil_slave.sv ====
/* AXI-Lite slave for the palette. Protection bits are ignored, responses are always OKAY
   and addresses wrap within the table. One write and one read may be outstanding */
`include "palette_defs.svh"

module palette_axil_slave (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  logic [`CT_ADDR_W-1:0]   s_axil_awaddr,
  input  logic [2:0]              s_axil_awprot,
  input  logic                    s_axil_awvalid,
  output logic                    s_axil_awready,
  input  logic [`CT_DATA_W-1:0]   s_axil_wdata,
  input  palette_pkg::ct_strb_t   s_axil_wstrb,
  input  logic                    s_axil_wvalid,
  output logic                    s_axil_wready,
  output logic                    s_axil_bvalid,
  output logic [1:0]              s_axil_bresp,
  input  logic                    s_axil_bready,
  input  logic [`CT_ADDR_W-1:0]   s_axil_araddr,
  input  logic [2:0]              s_axil_arprot,
  input  logic                    s_axil_arvalid,
  output logic                    s_axil_arready,
  output logic [`CT_DATA_W-1:0]   s_axil_rdata,
  output logic [1:0]              s_axil_rresp,
  output logic                    s_axil_rvalid,
  input  logic                    s_axil_rready,
  output palette_pkg::ct_req_t    bus_req,
  output logic                    bus_req_valid,
  input  logic                    bus_gnt,
  input  palette_pkg::ct_rsp_t    bus_rsp
);
  import palette_pkg::*;

  logic                  ports_up; // Keeps the ready signals low in the first cycle
  logic                  aw_held;
  logic                  w_held;
  ct_word_index_t        aw_index;
  logic [`CT_DATA_W-1:0] w_data;
  ct_strb_t              w_strb;
  ct_word_index_t        ar_index;
  axil_rd_state_t        rd_state;
  logic                  rd_issued; // Read granted, word not yet back
  logic                  wr_pending;
  logic                  rd_pending;

  // Byte address to entry pair, wrapping modulo the number of pairs
  function automatic ct_word_index_t pair_of(input logic [`CT_ADDR_W-1:0] addr);
    logic [`CT_ADDR_W-1:0] offset;
    offset = addr - `CT_BASE_ADDR;
    return offset[8:2];
  endfunction

  assign s_axil_awready = ports_up && !aw_held;
  assign s_axil_wready  = ports_up && !w_held;
  assign s_axil_arready = ports_up && (rd_state == RD_IDLE);
  assign s_axil_bresp   = 2'b00;
  assign s_axil_rresp   = 2'b00;

  // Writes go first when both are waiting for the table
  assign wr_pending    = aw_held && w_held && !s_axil_bvalid;
  assign rd_pending    = (rd_state == RD_WAIT) && !rd_issued && !wr_pending;
  assign bus_req_valid = wr_pending || rd_pending;

  always_comb begin
    bus_req.we    = wr_pending;
    bus_req.strb  = w_strb;
    bus_req.index = wr_pending ? aw_index : ar_index;
    bus_req.wdata = w_data;
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ports_up      <= 1'b0;
      aw_held       <= 1'b0;
      w_held        <= 1'b0;
      s_axil_bvalid <= 1'b0;
    end else begin
      ports_up <= 1'b1;
      if (s_axil_awvalid && s_axil_awready) aw_held <= 1'b1;
      if (s_axil_wvalid && s_axil_wready) w_held <= 1'b1;
      if (bus_gnt && wr_pending) s_axil_bvalid <= 1'b1; // Table written in the grant cycle
      // Both channels stay latched until B is taken, which blocks the next write
      if (s_axil_bvalid && s_axil_bready) begin
        s_axil_bvalid <= 1'b0;
        aw_held       <= 1'b0;
        w_held        <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (s_axil_awvalid && s_axil_awready) aw_index <= pair_of(s_axil_awaddr);
    if (s_axil_wvalid && s_axil_wready) begin
      w_data <= s_axil_wdata;
      w_strb <= s_axil_wstrb;
    end
    if (s_axil_arvalid && s_axil_arready) ar_index <= pair_of(s_axil_araddr);
    if (rd_state == RD_WAIT && rd_issued && bus_rsp.rvalid) s_axil_rdata <= bus_rsp.rdata;
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rd_state      <= RD_IDLE;
      rd_issued     <= 1'b0;
      s_axil_rvalid <= 1'b0;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (s_axil_arvalid && s_axil_arready) rd_state <= RD_WAIT;
        end
        RD_WAIT: begin
          if (rd_pending && bus_gnt) rd_issued <= 1'b1;
          if (rd_issued && bus_rsp.rvalid) begin
            rd_issued     <= 1'b0;
            s_axil_rvalid <= 1'b1;
            rd_state      <= RD_HOLD;
          end
        end
        RD_HOLD: begin
          if (s_axil_rready) begin
            s_axil_rvalid <= 1'b0;
            rd_state      <= RD_IDLE;
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  a_bvalid_held: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid);

  a_rvalid_held: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata));

endmodule

// ==== colour_table/palette_fill.sv ====
/* Writes the default grey ramp into every entry pair once after reset.
   Bus accesses to the table are held off until palette_ready is high */
`include "palette_defs.svh"

module palette_fill (
  input  logic                  aclk,
  input  logic                  aresetn,
  output palette_pkg::ct_req_t  fill_req,
  output logic                  fill_req_valid,
  input  logic                  fill_gnt,
  output logic                  palette_ready
);
  import palette_pkg::*;

  fill_state_t    state;
  ct_word_index_t pair;

  // The grey ramp gives red and blue 5 bits and green 6 bits of the index
  function automatic rgb565_t grey(input ct_index_t i);
    return {i[7:3], i[7:2], i[7:3]};
  endfunction

  assign fill_req_valid = (state == FILL_RUN);
  assign palette_ready  = (state == FILL_DONE);

  always_comb begin
    fill_req.we    = 1'b1;
    fill_req.strb  = 2'b11; // Both entries of the pair
    fill_req.index = pair;
    fill_req.wdata = {grey({pair, 1'b1}), grey({pair, 1'b0})};
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= FILL_IDLE;
      pair  <= '0;
    end else begin
      case (state)
        FILL_IDLE: state <= FILL_RUN;
        FILL_RUN: begin
          if (fill_gnt) begin
            pair <= pair + 1'b1;
            if (pair == ct_word_index_t'(`CT_PAIRS - 1)) state <= FILL_DONE;
          end
        end
        FILL_DONE: state <= FILL_DONE; // Rests here until the next reset
        default: state <= FILL_IDLE;
      endcase
    end
  end

endmodule

// ==== colour_table/palette_ram.sv ====
/* Dual-port colour table held in even and odd banks. Port A reads never collide with
   its own writes. Port B sees the old entry when A writes the same one */
`include "palette_defs.svh"

module palette_ram (
  input  logic                   aclk,
  input  logic                   porta_en,
  input  palette_pkg::ct_req_t   porta_req,
  output logic [31:0]            porta_rdata,
  input  palette_pkg::ct_index_t portb_index,
  output palette_pkg::rgb565_t   portb_data
);
  import palette_pkg::*;

  rgb565_t even_bank [`CT_PAIRS];
  rgb565_t odd_bank  [`CT_PAIRS];

  ct_word_index_t portb_pair;

  assign portb_pair = portb_index[7:1];

  // Port A, one strobe lane per bank
  always_ff @(posedge aclk) begin
    if (porta_en) begin
      if (porta_req.we) begin
        if (porta_req.strb[0]) even_bank[porta_req.index] <= porta_req.wdata[15:0];
        if (porta_req.strb[1]) odd_bank[porta_req.index]  <= porta_req.wdata[31:16];
      end else begin
        porta_rdata <= {odd_bank[porta_req.index], even_bank[porta_req.index]};
      end
    end
  end

  // Port B reads every cycle
  always_ff @(posedge aclk) begin
    if (portb_index[0]) begin
      portb_data <= odd_bank[portb_pair];
    end else begin
      portb_data <= even_bank[portb_pair];
    end
  end

endmodule

// ==== common/palette_defs.svh ====
/* Table geometry and AXI-Lite widths. Two RGB565 entries share each 32-bit bus word,
   so CT_DEPTH must stay even and the bus data width must stay 32 */
`ifndef PALETTE_DEFS_SVH
`define PALETTE_DEFS_SVH

// Number of RGB565 entries in the table
`define CT_DEPTH 256

// Number of 32-bit entry pairs
`define CT_PAIRS (`CT_DEPTH / 2)

// Byte address of entry 0 as seen from the CPU
`define CT_BASE_ADDR 32'h0000_4000

`define CT_ADDR_W 32 // AXI-Lite address width
`define CT_DATA_W 32 // AXI-Lite data width

// Width of one colour entry
`define CT_ENTRY_W 16

`endif

// ==== common/palette_pkg.sv ====
/* Shared types for the colour table. Entry pairs are packed with the even entry
   in the low half of the word */
`include "palette_defs.svh"

package palette_pkg;

  typedef logic [7:0] ct_index_t; // One table entry
  typedef logic [6:0] ct_word_index_t; // One pair of entries
  typedef logic [`CT_ENTRY_W-1:0] rgb565_t; // r[15:11] g[10:5] b[4:0]
  typedef logic [1:0] ct_strb_t; // Lane 0 selects the even entry

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb888_t;

  // Request to port A of the table
  typedef struct packed {
    logic                  we;
    ct_strb_t              strb;
    ct_word_index_t        index;
    logic [`CT_DATA_W-1:0] wdata;
  } ct_req_t;

  // Read data returned to the bus slave
  typedef struct packed {
    logic                  rvalid;
    logic [`CT_DATA_W-1:0] rdata;
  } ct_rsp_t;

  typedef enum logic [1:0] {
    FILL_IDLE,
    FILL_RUN,
    FILL_DONE
  } fill_state_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT,
    RD_HOLD
  } axil_rd_state_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# Builds the colour table testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module tb_colour_table \
  -o sim_colour_table || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_colour_table > sim.log 2>&1
cat sim.log
grep -q "test failed" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "test passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

// ==== src.f ====
+incdir+common
common/palette_pkg.sv
colour_table/palette_ram.sv
colour_table/palette_arbiter.sv
colour_table/palette_fill.sv
colour_table/palette_axil_slave.sv
verilog/scanout_lookup.sv
verilog/colour_table_top.sv
verif/tb_colour_table.sv

// ==== verif/tb_colour_table.sv ====
/* Testbench for the colour table. Scanout indices stay in pairs 0..63 while bus writes
   that run alongside the scanout go to pairs 64..127, so the expected colours stay fixed */
`include "palette_defs.svh"

module tb_colour_table;
  timeunit 1ns;
  timeprecision 100ps;
  import palette_pkg::*;

  localparam int PERIOD = 40;
  localparam int N_INIT_RD = 16;
  localparam int N_EARLY = 4;
  localparam int N_WR = 24;
  localparam int N_STRB = 16;
  localparam int N_PIX = 64;
  localparam int N_BP = 16;
  localparam int OP_CYCLES = 24; // One bus access with arbitration and up to 7 stall cycles
  localparam int FILL_CYCLES = `CT_PAIRS + 16;
  localparam int TEST_CYCLES = 2 * FILL_CYCLES + N_PIX
    + OP_CYCLES * (N_INIT_RD + 2 * N_EARLY + 3 * N_WR + 2 * N_STRB + 2 * N_BP + N_PIX / 8);

  logic                  aclk;
  logic                  aresetn;
  logic [`CT_ADDR_W-1:0] s_axil_awaddr;
  logic [2:0]            s_axil_awprot;
  logic                  s_axil_awvalid;
  logic                  s_axil_awready;
  logic [`CT_DATA_W-1:0] s_axil_wdata;
  ct_strb_t              s_axil_wstrb;
  logic                  s_axil_wvalid;
  logic                  s_axil_wready;
  logic                  s_axil_bvalid;
  logic [1:0]            s_axil_bresp;
  logic                  s_axil_bready;
  logic [`CT_ADDR_W-1:0] s_axil_araddr;
  logic [2:0]            s_axil_arprot;
  logic                  s_axil_arvalid;
  logic                  s_axil_arready;
  logic [`CT_DATA_W-1:0] s_axil_rdata;
  logic [1:0]            s_axil_rresp;
  logic                  s_axil_rvalid;
  logic                  s_axil_rready;
  logic                  palette_ready;
  logic                  pix_valid;
  ct_index_t             pix_index;
  logic                  pix_last;
  logic                  rgb_valid;
  rgb888_t               rgb;
  logic                  rgb_last;

  rgb565_t     shadow [`CT_DEPTH]; // Expected table contents
  ct_index_t   pix_list [N_PIX];
  int          early_pair [N_EARLY];
  logic [31:0] lcg_state = 32'he8e1_6025;
  logic [31:0] exp_rdata = '0; // Word the pending read must return
  logic [1:0]  exp_valid;
  logic [1:0]  exp_last;
  rgb888_t     exp_rgb [2];
  int          bp_max = 0; // Longest bready or rready stall
  int          wr_issued = 0;
  int          wr_done = 0;
  int          rd_issued = 0;
  int          rd_done = 0;

  colour_table_top dut0 (.*);

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[30:16]) % n; // The upper bits, since the low ones cycle quickly
  endfunction

  // Red and blue take the top 5 index bits and green the top 6
  function automatic rgb565_t grey_entry(input int i);
    return rgb565_t'(((i >> 3) << 11) | ((i >> 2) << 5) | (i >> 3));
  endfunction

  function automatic rgb888_t to_rgb888(input rgb565_t c);
    rgb888_t px;
    int      r5;
    int      g6;
    int      b5;
    r5 = int'(c[15:11]);
    g6 = int'(c[10:5]);
    b5 = int'(c[4:0]);
    px.r = 8'((r5 << 3) | (r5 >> 2));
    px.g = 8'((g6 << 2) | (g6 >> 4));
    px.b = 8'((b5 << 3) | (b5 >> 2));
    return px;
  endfunction

  function automatic logic [31:0] shadow_pair(input int p);
    return {shadow[2 * p + 1], shadow[2 * p]}; // Even entry in the low half
  endfunction

  task automatic report_error(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("test failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic shadow_to_grey();
    for (int i = 0; i < `CT_DEPTH; i++) shadow[i] = grey_entry(i);
  endtask

  task automatic apply_reset();
    @(posedge aclk);
    aresetn <= 1'b0;
    repeat (5) @(posedge aclk);
    aresetn <= 1'b1;
  endtask

  task automatic wait_palette_ready();
    while (!palette_ready) @(posedge aclk);
  endtask

  task automatic bus_write(input int pair, input logic [31:0] data, input ct_strb_t strb);
    int   aw_wait;
    int   w_wait;
    int   b_wait;
    int   cyc;
    logic aw_sent;
    logic w_sent;
    aw_wait = rand_below(3); // AW and W reach the slave in either order
    w_wait  = rand_below(3);
    b_wait  = rand_below(bp_max + 1);
    if (strb[0]) shadow[2 * pair] = data[15:0];
    if (strb[1]) shadow[2 * pair + 1] = data[31:16];
    wr_issued++;
    aw_sent = 1'b0;
    w_sent  = 1'b0;
    cyc     = 0;
    while (!(aw_sent && w_sent)) begin
      @(posedge aclk);
      if (s_axil_awvalid && s_axil_awready) begin
        s_axil_awvalid <= 1'b0;
        aw_sent = 1'b1;
      end else if (!aw_sent && !s_axil_awvalid && cyc >= aw_wait) begin
        s_axil_awaddr  <= `CT_BASE_ADDR + 32'(pair * 4);
        s_axil_awvalid <= 1'b1;
      end
      if (s_axil_wvalid && s_axil_wready) begin
        s_axil_wvalid <= 1'b0;
        w_sent = 1'b1;
      end else if (!w_sent && !s_axil_wvalid && cyc >= w_wait) begin
        s_axil_wdata  <= data;
        s_axil_wstrb  <= strb;
        s_axil_wvalid <= 1'b1;
      end
      cyc++;
    end
    cyc = 0;
    while (!(s_axil_bvalid && s_axil_bready)) begin
      @(posedge aclk);
      if (s_axil_bvalid && !s_axil_bready) begin
        if (cyc >= b_wait) s_axil_bready <= 1'b1;
        cyc++;
      end
    end
    s_axil_bready <= 1'b0;
  endtask

  task automatic bus_read(input int pair);
    int r_wait;
    int cyc;
    r_wait = rand_below(bp_max + 1);
    @(posedge aclk);
    exp_rdata = shadow_pair(pair);
    rd_issued++;
    s_axil_araddr  <= `CT_BASE_ADDR + 32'(pair * 4);
    s_axil_arvalid <= 1'b1;
    do @(posedge aclk); while (!s_axil_arready);
    s_axil_arvalid <= 1'b0;
    cyc = 0;
    while (!(s_axil_rvalid && s_axil_rready)) begin
      @(posedge aclk);
      if (s_axil_rvalid && !s_axil_rready) begin
        if (cyc >= r_wait) s_axil_rready <= 1'b1;
        cyc++;
      end
    end
    s_axil_rready <= 1'b0;
  endtask

  task automatic drive_pixels();
    for (int i = 0; i < N_PIX; i++) begin
      @(posedge aclk);
      pix_valid <= 1'b1;
      pix_index <= pix_list[i];
      pix_last  <= (i == N_PIX - 1);
    end
    @(posedge aclk);
    pix_valid <= 1'b0;
    pix_last  <= 1'b0;
    repeat (3) @(posedge aclk); // Lets the last pixels leave the 2-cycle pipeline
  endtask

  initial begin
    aclk = 1'b0;
    forever #(PERIOD / 2) aclk = ~aclk;
  end

  initial begin
    #(4 * TEST_CYCLES * PERIOD);
    $display("Watchdog expired after %0d cycles before the tests finished", 4 * TEST_CYCLES);
    $display("test failed");
    $fatal(1, "Watchdog timeout");
  end

  // The expected scanout stream runs two cycles behind the pixel input
  always @(posedge aclk) begin
    if (!aresetn) begin
      exp_valid <= '0;
      exp_last  <= '0;
    end else begin
      exp_valid <= {exp_valid[0], pix_valid};
      exp_last  <= {exp_last[0], pix_valid && pix_last};
    end
    exp_rgb[1] <= exp_rgb[0];
    exp_rgb[0] <= to_rgb888(shadow[pix_index]);
  end

  always @(posedge aclk) begin
    if (s_axil_bvalid && s_axil_bready) wr_done <= wr_done + 1;
    if (s_axil_rvalid && s_axil_rready) rd_done <= rd_done + 1;
  end

  a_reset_state: assert property (@(posedge aclk) $rose(aresetn) |->
      !s_axil_bvalid && !s_axil_rvalid && !rgb_valid && !palette_ready
      && !s_axil_awready && !s_axil_wready && !s_axil_arready)
    else report_error("outputs not idle in the first cycle after reset");

  a_ready_stays: assert property (@(posedge aclk) disable iff (!aresetn)
      palette_ready |=> palette_ready)
    else report_error("palette_ready fell without a reset");

  a_rdata: assert property (@(posedge aclk) disable iff (!aresetn)
      s_axil_rvalid |-> s_axil_rdata == exp_rdata)
    else report_error($sformatf("rdata %h, expected %h", $sampled(s_axil_rdata),
                                $sampled(exp_rdata)));

  a_bresp: assert property (@(posedge aclk) disable iff (!aresetn)
      s_axil_bvalid |-> s_axil_bresp == 2'b00)
    else report_error($sformatf("bresp %b, expected 00", $sampled(s_axil_bresp)));

  a_rresp: assert property (@(posedge aclk) disable iff (!aresetn)
      s_axil_rvalid |-> s_axil_rresp == 2'b00)
    else report_error($sformatf("rresp %b, expected 00", $sampled(s_axil_rresp)));

  a_b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
      s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
    else report_error("bvalid dropped before bready");

  a_r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
      s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata))
    else report_error("rvalid or rdata changed before rready");

  a_b_once: assert property (@(posedge aclk) disable iff (!aresetn)
      s_axil_bvalid |-> wr_done < wr_issued)
    else report_error("bvalid high without an outstanding write");

  a_r_once: assert property (@(posedge aclk) disable iff (!aresetn)
      s_axil_rvalid |-> rd_done < rd_issued)
    else report_error("rvalid high without an outstanding read");

  a_rgb_valid: assert property (@(posedge aclk) disable iff (!aresetn)
      rgb_valid == exp_valid[1])
    else report_error("rgb_valid not 2 cycles after pix_valid");

  a_rgb_data: assert property (@(posedge aclk) disable iff (!aresetn)
      rgb_valid |-> rgb == exp_rgb[1] && rgb_last == exp_last[1])
    else report_error($sformatf("rgb %h last %b, expected %h last %b", $sampled(rgb),
                                $sampled(rgb_last), $sampled(exp_rgb[1]),
                                $sampled(exp_last[1])));

  initial begin
    int p;
    aresetn        = 1'b0;
    s_axil_awaddr  = '0;
    s_axil_awprot  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_araddr  = '0;
    s_axil_arprot  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b0;
    pix_valid      = 1'b0;
    pix_index      = '0;
    pix_last       = 1'b0;
    shadow_to_grey();
    apply_reset();
    wait_palette_ready();
    repeat (N_INIT_RD) bus_read(rand_below(`CT_PAIRS)); // Default grey ramp
    // A second reset lets the first write land while the fill is still running
    apply_reset();
    shadow_to_grey();
    assert (!palette_ready) else report_error("palette_ready high right after reset");
    for (int i = 0; i < N_EARLY; i++) begin
      early_pair[i] = rand_below(`CT_PAIRS);
      bus_write(early_pair[i], lcg_next(), 2'b11);
    end
    wait_palette_ready();
    for (int i = 0; i < N_EARLY; i++) bus_read(early_pair[i]);
    for (int i = 0; i < N_WR; i++) begin
      p = rand_below(`CT_PAIRS);
      bus_write(p, lcg_next(), 2'b11);
      bus_read(p);
      bus_read(rand_below(`CT_PAIRS));
    end
    for (int i = 0; i < N_STRB; i++) begin
      p = rand_below(`CT_PAIRS);
      bus_write(p, lcg_next(), ct_strb_t'(rand_below(2) + 1)); // One lane only
      bus_read(p);
    end
    for (int i = 0; i < N_PIX; i++) pix_list[i] = ct_index_t'(rand_below(`CT_DEPTH / 2));
    fork
      drive_pixels();
      for (int k = 0; k < N_PIX / 8; k++) begin
        bus_write(`CT_PAIRS / 2 + rand_below(`CT_PAIRS / 2), lcg_next(), 2'b11);
      end
    join
    bp_max = 7;
    for (int i = 0; i < N_BP; i++) begin
      p = rand_below(`CT_PAIRS);
      bus_write(p, lcg_next(), 2'b11);
      bus_read(p);
    end
    bp_max = 0;
    repeat (2) @(posedge aclk);
    if (wr_done == wr_issued && rd_done == rd_issued) begin
      $display("test passed");
      $finish;
    end else begin
      report_error($sformatf("%0d of %0d writes and %0d of %0d reads completed",
                             wr_done, wr_issued, rd_done, rd_issued));
    end
  end

endmodule

// ==== verilog/colour_table_top.sv ====
/* Colour palette subsystem top level. The table is filled with a grey ramp after reset,
   bus writes made before palette_ready still land after the fill writes */
`include "palette_defs.svh"

module colour_table_top (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  logic [`CT_ADDR_W-1:0]  s_axil_awaddr,
  input  logic [2:0]             s_axil_awprot,
  input  logic                   s_axil_awvalid,
  output logic                   s_axil_awready,
  input  logic [`CT_DATA_W-1:0]  s_axil_wdata,
  input  palette_pkg::ct_strb_t  s_axil_wstrb,
  input  logic                   s_axil_wvalid,
  output logic                   s_axil_wready,
  output logic                   s_axil_bvalid,
  output logic [1:0]             s_axil_bresp,
  input  logic                   s_axil_bready,
  input  logic [`CT_ADDR_W-1:0]  s_axil_araddr,
  input  logic [2:0]             s_axil_arprot,
  input  logic                   s_axil_arvalid,
  output logic                   s_axil_arready,
  output logic [`CT_DATA_W-1:0]  s_axil_rdata,
  output logic [1:0]             s_axil_rresp,
  output logic                   s_axil_rvalid,
  input  logic                   s_axil_rready,
  output logic                   palette_ready,
  input  logic                   pix_valid,
  input  palette_pkg::ct_index_t pix_index,
  input  logic                   pix_last,
  output logic                   rgb_valid,
  output palette_pkg::rgb888_t   rgb,
  output logic                   rgb_last
);
  import palette_pkg::*;

  ct_req_t     bus_req;
  logic        bus_req_valid;
  logic        bus_gnt;
  ct_rsp_t     bus_rsp;
  ct_req_t     fill_req;
  logic        fill_req_valid;
  logic        fill_gnt;
  ct_req_t     ram_req;
  logic        ram_en;
  logic [31:0] ram_rdata;
  ct_index_t   portb_index;
  rgb565_t     portb_data;

  palette_axil_slave slave0 (
    .aclk, .aresetn,
    .s_axil_awaddr, .s_axil_awprot, .s_axil_awvalid, .s_axil_awready,
    .s_axil_wdata, .s_axil_wstrb, .s_axil_wvalid, .s_axil_wready,
    .s_axil_bvalid, .s_axil_bresp, .s_axil_bready,
    .s_axil_araddr, .s_axil_arprot, .s_axil_arvalid, .s_axil_arready,
    .s_axil_rdata, .s_axil_rresp, .s_axil_rvalid, .s_axil_rready,
    .bus_req, .bus_req_valid, .bus_gnt, .bus_rsp
  );

  palette_fill fill0 (
    .aclk, .aresetn, .fill_req, .fill_req_valid, .fill_gnt, .palette_ready
  );

  palette_arbiter arb0 (
    .aclk, .aresetn,
    .fill_req, .fill_req_valid, .fill_gnt,
    .bus_req, .bus_req_valid, .bus_gnt,
    .ram_req, .ram_en, .ram_rdata, .bus_rsp
  );

  palette_ram ram0 (
    .aclk,
    .porta_en    (ram_en),
    .porta_req   (ram_req),
    .porta_rdata (ram_rdata),
    .portb_index,
    .portb_data
  );

  scanout_lookup lookup0 (
    .aclk, .aresetn, .pix_valid, .pix_index, .pix_last,
    .portb_index, .portb_data, .rgb_valid, .rgb, .rgb_last
  );

endmodule

// ==== verilog/scanout_lookup.sv ====
/* Pixel index to RGB888 lookup with a fixed latency of 2 cycles. The stream has
   no ready, so a pixel may enter every cycle */
module scanout_lookup (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  logic                   pix_valid,
  input  palette_pkg::ct_index_t pix_index,
  input  logic                   pix_last,
  output palette_pkg::ct_index_t portb_index,
  input  palette_pkg::rgb565_t   portb_data,
  output logic                   rgb_valid,
  output palette_pkg::rgb888_t   rgb,
  output logic                   rgb_last
);
  import palette_pkg::*;

  logic lookup_valid; // Stage 1 marks the table read in flight
  logic lookup_last;

  // Each channel moves to the top byte and repeats its own high bits below
  function automatic rgb888_t expand(input rgb565_t c);
    rgb888_t px;
    px.r = {c[15:11], c[15:13]};
    px.g = {c[10:5], c[10:9]};
    px.b = {c[4:0], c[4:2]};
    return px;
  endfunction

  assign portb_index = pix_index; // Table registers the entry in stage 1

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      lookup_valid <= 1'b0;
      lookup_last  <= 1'b0;
      rgb_valid    <= 1'b0;
      rgb_last     <= 1'b0;
    end else begin
      lookup_valid <= pix_valid;
      lookup_last  <= pix_valid && pix_last;
      rgb_valid    <= lookup_valid;
      rgb_last     <= lookup_last;
    end
  end

  always_ff @(posedge aclk) begin
    rgb <= expand(portb_data); // Stage 2
  end

endmodule
